// File: rtl/tinker_pkg.sv
package tinker_pkg;

    // basic widths
    localparam int ADDR_W    = 32;
    localparam int INSTR_W   = 32;
    localparam int DATA_W    = 64;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 5;
    localparam int LIT_W     = 12;
    localparam int NUM_REGS  = 32;

    typedef logic [ADDR_W-1:0]    addr_t;    // byte address
    typedef logic [INSTR_W-1:0]   instr_t;   // one instruction word
    typedef logic [DATA_W-1:0]    data_t;    // register / memory value
    typedef logic [REG_IDX_W-1:0] reg_idx_t; // register number
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [LIT_W-1:0]     lit_t;     // literal field

    // opcodes, bits [31:27] of the word
    localparam opcode_t OP_AND    = 5'h00;
    localparam opcode_t OP_OR     = 5'h01;
    localparam opcode_t OP_XOR    = 5'h02;
    localparam opcode_t OP_NOT    = 5'h03;
    localparam opcode_t OP_SHFTR  = 5'h04;
    localparam opcode_t OP_SHFTRI = 5'h05;
    localparam opcode_t OP_SHFTL  = 5'h06;
    localparam opcode_t OP_SHFTLI = 5'h07;
    localparam opcode_t OP_BR     = 5'h08; // pc = rd
    localparam opcode_t OP_BRR_RD = 5'h09; // pc = pc + rd
    localparam opcode_t OP_BRR_L  = 5'h0a; // pc = pc + sext(L)
    localparam opcode_t OP_BRNZ   = 5'h0b; // pc = rd if rs != 0
    localparam opcode_t OP_BRGT   = 5'h0e; // pc = rd if rs > rt, signed
    localparam opcode_t OP_HALT   = 5'h0f;
    localparam opcode_t OP_LOAD   = 5'h10; // rd = mem[rs + L]
    localparam opcode_t OP_MOV_RR = 5'h11;
    localparam opcode_t OP_MOV_RL = 5'h12; // low 12 bits of rd only
    localparam opcode_t OP_STORE  = 5'h13; // mem[rd + L] = rt
    localparam opcode_t OP_ADD    = 5'h18;
    localparam opcode_t OP_ADDI   = 5'h19;
    localparam opcode_t OP_SUB    = 5'h1a;
    localparam opcode_t OP_SUBI   = 5'h1b;
    localparam opcode_t OP_MUL    = 5'h1c;

    localparam instr_t NOP_INSTR   = 32'h8800_0000; // mov r0, r0
    localparam addr_t  INSTR_BYTES = 32'd4;         // pc step

    // control bits carried down the pipe
    typedef struct packed {
        logic reg_write;  // writes rd in WB
        logic mem_read;   // load, used by the hazard check
        logic mem_write;  // store in MEM
        logic mem_to_reg; // WB takes loaded data
        logic halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        lit_t     lit;
        data_t    rd_val; // raw regfile values, forwarding happens in EX
        data_t    rs_val;
        data_t    rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        data_t    alu_result; // also the memory address for load/store
        data_t    store_data;
        reg_idx_t rd_dest;
    } exmem_t;

    // writeback channel, also the MEM/WB forwarding source
    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        data_t    data;
    } wb_t;

    typedef enum logic [1:0] {
        FWD_RF    = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic  we;    // store strobe
        addr_t addr;  // byte address, 8 bytes little endian
        data_t wdata;
    } dmem_req_t;

endpackage

// File: rtl/tinker_fetch.sv
`timescale 1ns/1ns

module tinker_fetch #(
    parameter tinker_pkg::addr_t PC_RESET_ADDR = 32'h2000
) (
    input  logic               clk,
    input  logic               reset,
    input  tinker_pkg::instr_t imem_data,     // word at imem_addr, same cycle
    input  logic               stall,         // load-use hold
    input  logic               flush,         // taken branch in ID
    input  tinker_pkg::addr_t  branch_target,
    output tinker_pkg::addr_t  imem_addr,
    output tinker_pkg::addr_t  pc_ifid,
    output tinker_pkg::instr_t instr_ifid
);

    tinker_pkg::addr_t pc;
    tinker_pkg::addr_t pc_next;

    assign imem_addr = pc;

    // redirect wins over the sequential step
    assign pc_next = flush ? branch_target : pc + tinker_pkg::INSTR_BYTES;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= PC_RESET_ADDR;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_ifid    <= '0;
            instr_ifid <= tinker_pkg::NOP_INSTR; // start with a bubble
        end else if (!stall) begin
            pc_ifid <= pc;
            if (flush) begin
                instr_ifid <= tinker_pkg::NOP_INSTR; // squash wrong-path word
            end else begin
                instr_ifid <= imem_data;
            end
        end
    end

endmodule

// File: rtl/tinker_decode.sv
`timescale 1ns/1ns

module tinker_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::addr_t    pc_ifid,
    input  tinker_pkg::instr_t   instr_ifid,
    input  tinker_pkg::data_t    rd_val,
    input  tinker_pkg::data_t    rs_val,
    input  tinker_pkg::data_t    rt_val,
    output tinker_pkg::reg_idx_t rd_idx,
    output tinker_pkg::reg_idx_t rs_idx,
    output tinker_pkg::reg_idx_t rt_idx,
    output logic                 stall,
    output logic                 flush,
    output tinker_pkg::addr_t    branch_target,
    output tinker_pkg::idex_t    idex
);

    tinker_pkg::opcode_t op;
    tinker_pkg::lit_t    lit;
    tinker_pkg::ctrl_t   ctrl;
    tinker_pkg::idex_t   idex_next;
    tinker_pkg::addr_t   lit_sext;  // literal as a pc offset
    logic                take_branch;

    // field split
    assign op     = instr_ifid[31:27];
    assign rd_idx = instr_ifid[26:22];
    assign rs_idx = instr_ifid[21:17];
    assign rt_idx = instr_ifid[16:12];
    assign lit    = instr_ifid[11:0];

    assign lit_sext = {{(tinker_pkg::ADDR_W - tinker_pkg::LIT_W){lit[tinker_pkg::LIT_W-1]}}, lit};

    // control generation
    always_comb begin
        ctrl = '0;
        case (op)
            tinker_pkg::OP_AND, tinker_pkg::OP_OR, tinker_pkg::OP_XOR, tinker_pkg::OP_NOT,
            tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI, tinker_pkg::OP_SHFTL,
            tinker_pkg::OP_SHFTLI, tinker_pkg::OP_MOV_RR, tinker_pkg::OP_MOV_RL,
            tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI, tinker_pkg::OP_SUB, tinker_pkg::OP_SUBI,
            tinker_pkg::OP_MUL: begin
                ctrl.reg_write = 1'b1; // plain alu result to rd
            end
            tinker_pkg::OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            tinker_pkg::OP_STORE: ctrl.mem_write = 1'b1;
            tinker_pkg::OP_HALT:  ctrl.halt      = 1'b1;
            default:              ctrl           = '0; // branches and dropped ops
        endcase
    end

    // branch decision, regfile values only
    always_comb begin
        take_branch   = 1'b0;
        branch_target = pc_ifid + tinker_pkg::INSTR_BYTES;
        case (op)
            tinker_pkg::OP_BR: begin
                take_branch   = 1'b1;
                branch_target = rd_val[tinker_pkg::ADDR_W-1:0];
            end
            tinker_pkg::OP_BRR_RD: begin
                take_branch   = 1'b1;
                branch_target = pc_ifid + rd_val[tinker_pkg::ADDR_W-1:0]; // relative
            end
            tinker_pkg::OP_BRR_L: begin
                take_branch   = 1'b1;
                branch_target = pc_ifid + lit_sext;
            end
            tinker_pkg::OP_BRNZ: begin
                take_branch   = (rs_val != '0);
                branch_target = rd_val[tinker_pkg::ADDR_W-1:0];
            end
            tinker_pkg::OP_BRGT: begin
                take_branch   = ($signed(rs_val) > $signed(rt_val));
                branch_target = rd_val[tinker_pkg::ADDR_W-1:0];
            end
            default: take_branch = 1'b0;
        endcase
    end

    // load in ID/EX feeding this instruction -> hold one cycle
    assign stall = idex.ctrl.mem_read && ((idex.rd == rs_idx) || (idex.rd == rt_idx));

    // branch redirects only once it is no longer held
    assign flush = take_branch && !stall;

    always_comb begin
        idex_next.ctrl   = ctrl;
        idex_next.opcode = op;
        idex_next.rd     = rd_idx;
        idex_next.rs     = rs_idx;
        idex_next.rt     = rt_idx;
        idex_next.lit    = lit;
        idex_next.rd_val = rd_val;
        idex_next.rs_val = rs_val;
        idex_next.rt_val = rt_val;
    end

    // ID/EX register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex <= '0;
        end else if (stall) begin
            idex <= '0; // bubble, no control bits
        end else begin
            idex <= idex_next;
        end
    end

endmodule

// File: rtl/tinker_regfile.sv
`timescale 1ns/1ns

module tinker_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::wb_t      wb,
    input  tinker_pkg::reg_idx_t rd_idx,
    input  tinker_pkg::reg_idx_t rs_idx,
    input  tinker_pkg::reg_idx_t rt_idx,
    output tinker_pkg::data_t    rd_val,
    output tinker_pkg::data_t    rs_val,
    output tinker_pkg::data_t    rt_val
);

    tinker_pkg::data_t regs [tinker_pkg::NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < tinker_pkg::NUM_REGS; i++) begin
                regs[i] <= '0; // every register starts at zero
            end
        end else if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through so ID sees the value WB writes this cycle
    assign rd_val = (wb.we && (wb.dest == rd_idx)) ? wb.data : regs[rd_idx];
    assign rs_val = (wb.we && (wb.dest == rs_idx)) ? wb.data : regs[rs_idx];
    assign rt_val = (wb.we && (wb.dest == rt_idx)) ? wb.data : regs[rt_idx];

endmodule

// File: rtl/tinker_execute.sv
`timescale 1ns/1ns

module tinker_execute (
    input  logic               clk,
    input  logic               reset,
    input  tinker_pkg::idex_t  idex,
    input  tinker_pkg::wb_t    wb,    // MEM/WB result
    output tinker_pkg::exmem_t exmem
);

    tinker_pkg::fwd_sel_t sel_rd;
    tinker_pkg::fwd_sel_t sel_rs;
    tinker_pkg::fwd_sel_t sel_rt;
    tinker_pkg::data_t    op_rd;  // rd is the base of immediates and stores
    tinker_pkg::data_t    op_rs;
    tinker_pkg::data_t    op_rt;
    tinker_pkg::data_t    lit_zext;
    tinker_pkg::data_t    lit_sext;
    tinker_pkg::data_t    alu_out;
    tinker_pkg::exmem_t   exmem_next;

    // newest writer of a register wins
    function automatic tinker_pkg::fwd_sel_t pick_fwd(input tinker_pkg::reg_idx_t idx,
                                                      input tinker_pkg::exmem_t   em,
                                                      input tinker_pkg::wb_t      w);
        if (em.ctrl.reg_write && (em.rd_dest == idx)) begin
            return tinker_pkg::FWD_EXMEM;
        end else if (w.we && (w.dest == idx)) begin
            return tinker_pkg::FWD_MEMWB;
        end
        return tinker_pkg::FWD_RF;
    endfunction

    function automatic tinker_pkg::data_t fwd_mux(input tinker_pkg::fwd_sel_t sel,
                                                  input tinker_pkg::data_t    rf_val,
                                                  input tinker_pkg::data_t    em_val,
                                                  input tinker_pkg::data_t    wb_val);
        case (sel)
            tinker_pkg::FWD_EXMEM: return em_val;
            tinker_pkg::FWD_MEMWB: return wb_val;
            default:               return rf_val;
        endcase
    endfunction

    assign sel_rd = pick_fwd(idex.rd, exmem, wb);
    assign sel_rs = pick_fwd(idex.rs, exmem, wb);
    assign sel_rt = pick_fwd(idex.rt, exmem, wb);

    assign op_rd = fwd_mux(sel_rd, idex.rd_val, exmem.alu_result, wb.data);
    assign op_rs = fwd_mux(sel_rs, idex.rs_val, exmem.alu_result, wb.data);
    assign op_rt = fwd_mux(sel_rt, idex.rt_val, exmem.alu_result, wb.data);

    assign lit_zext = {{(tinker_pkg::DATA_W - tinker_pkg::LIT_W){1'b0}}, idex.lit};
    assign lit_sext = {{(tinker_pkg::DATA_W - tinker_pkg::LIT_W){idex.lit[tinker_pkg::LIT_W-1]}},
                       idex.lit};

    // integer alu
    always_comb begin
        case (idex.opcode)
            tinker_pkg::OP_ADD:    alu_out = op_rs + op_rt;
            tinker_pkg::OP_ADDI:   alu_out = op_rd + lit_zext;
            tinker_pkg::OP_SUB:    alu_out = op_rs - op_rt;
            tinker_pkg::OP_SUBI:   alu_out = op_rd - lit_zext;
            tinker_pkg::OP_MUL:    alu_out = op_rs * op_rt;  // low 64 bits kept
            tinker_pkg::OP_AND:    alu_out = op_rs & op_rt;
            tinker_pkg::OP_OR:     alu_out = op_rs | op_rt;
            tinker_pkg::OP_XOR:    alu_out = op_rs ^ op_rt;
            tinker_pkg::OP_NOT:    alu_out = ~op_rs;         // rt ignored
            tinker_pkg::OP_SHFTR:  alu_out = op_rs >> op_rt; // logical
            tinker_pkg::OP_SHFTRI: alu_out = op_rd >> lit_zext;
            tinker_pkg::OP_SHFTL:  alu_out = op_rs << op_rt;
            tinker_pkg::OP_SHFTLI: alu_out = op_rd << lit_zext;
            tinker_pkg::OP_MOV_RR: alu_out = op_rs;
            tinker_pkg::OP_MOV_RL: begin
                alu_out = {op_rd[tinker_pkg::DATA_W-1:tinker_pkg::LIT_W], idex.lit};
            end
            tinker_pkg::OP_LOAD:   alu_out = op_rs + lit_sext; // load address
            tinker_pkg::OP_STORE:  alu_out = op_rd + lit_sext; // store address
            default:               alu_out = '0;
        endcase
    end

    always_comb begin
        exmem_next.ctrl       = idex.ctrl;
        exmem_next.alu_result = alu_out;
        exmem_next.store_data = op_rt; // forwarded, so a fresh value gets stored
        exmem_next.rd_dest    = idex.rd;
    end

    // EX/MEM register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem <= '0;
        end else begin
            exmem <= exmem_next;
        end
    end

endmodule

// File: rtl/tinker_writeback.sv
`timescale 1ns/1ns

module tinker_writeback (
    input  logic               clk,
    input  logic               reset,
    input  tinker_pkg::exmem_t exmem,
    input  tinker_pkg::data_t  dmem_rdata, // load data at exmem address
    output tinker_pkg::wb_t    wb,
    output logic               hlt
);

    typedef struct packed {
        tinker_pkg::ctrl_t    ctrl;
        tinker_pkg::data_t    alu_result;
        tinker_pkg::data_t    mem_data;
        tinker_pkg::reg_idx_t dest;
    } memwb_t;

    memwb_t memwb;

    // MEM/WB register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb <= '0;
        end else begin
            memwb.ctrl       <= exmem.ctrl;
            memwb.alu_result <= exmem.alu_result;
            memwb.mem_data   <= dmem_rdata; // only meaningful for loads
            memwb.dest       <= exmem.rd_dest;
        end
    end

    // result select
    always_comb begin
        wb.we   = memwb.ctrl.reg_write;
        wb.dest = memwb.dest;
        wb.data = memwb.ctrl.mem_to_reg ? memwb.mem_data : memwb.alu_result;
    end

    assign hlt = memwb.ctrl.halt; // one cycle, while halt sits in MEM/WB

endmodule

// File: rtl/tinker_core.sv
`timescale 1ns/1ns

module tinker_core #(
    parameter tinker_pkg::addr_t PC_RESET_ADDR = 32'h2000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  tinker_pkg::instr_t    imem_data,
    input  tinker_pkg::data_t     dmem_rdata,
    output tinker_pkg::addr_t     imem_addr,
    output tinker_pkg::dmem_req_t dmem_req,
    output logic                  hlt
);

    // IF -> ID
    tinker_pkg::addr_t    pc_ifid;
    tinker_pkg::instr_t   instr_ifid;

    // ID -> IF
    logic                 stall;
    logic                 flush;
    tinker_pkg::addr_t    branch_target;

    // ID <-> regfile
    tinker_pkg::reg_idx_t rd_idx;
    tinker_pkg::reg_idx_t rs_idx;
    tinker_pkg::reg_idx_t rt_idx;
    tinker_pkg::data_t    rd_val;
    tinker_pkg::data_t    rs_val;
    tinker_pkg::data_t    rt_val;

    // stage registers
    tinker_pkg::idex_t    idex;
    tinker_pkg::exmem_t   exmem;
    tinker_pkg::wb_t      wb;    // to regfile and EX forwarding

    tinker_fetch #(
        .PC_RESET_ADDR (PC_RESET_ADDR)
    ) u_fetch (
        .clk           (clk),
        .reset         (reset),
        .imem_data     (imem_data),
        .stall         (stall),
        .flush         (flush),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .pc_ifid       (pc_ifid),
        .instr_ifid    (instr_ifid)
    );

    tinker_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .pc_ifid       (pc_ifid),
        .instr_ifid    (instr_ifid),
        .rd_val        (rd_val),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .rd_idx        (rd_idx),
        .rs_idx        (rs_idx),
        .rt_idx        (rt_idx),
        .stall         (stall),
        .flush         (flush),
        .branch_target (branch_target),
        .idex          (idex)
    );

    tinker_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .wb     (wb),
        .rd_idx (rd_idx),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rd_val (rd_val),
        .rs_val (rs_val),
        .rt_val (rt_val)
    );

    tinker_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .idex  (idex),
        .wb    (wb),
        .exmem (exmem)
    );

    // MEM stage is just the data port
    assign dmem_req.we    = exmem.ctrl.mem_write;
    assign dmem_req.addr  = exmem.alu_result[tinker_pkg::ADDR_W-1:0];
    assign dmem_req.wdata = exmem.store_data;

    tinker_writeback u_writeback (
        .clk        (clk),
        .reset      (reset),
        .exmem      (exmem),
        .dmem_rdata (dmem_rdata),
        .wb         (wb),
        .hlt        (hlt)
    );

endmodule

// File: verification/tinker_core_assertions.sv
`timescale 1ns/1ns

module tinker_core_assertions (
    input logic              clk,
    input logic              reset,
    input logic              stall,
    input logic              dmem_we,
    input tinker_pkg::addr_t imem_addr,
    input logic              hlt
);

    // stage registers come out of reset empty
    property no_store_after_reset;
        @(posedge clk) $fell(reset) |-> !dmem_we;
    endproperty

    // pc holds while decode waits on a load
    property pc_holds_on_stall;
        @(posedge clk) disable iff (reset) stall |=> $stable(imem_addr);
    endproperty

    property hlt_known;
        @(posedge clk) !$isunknown(hlt);
    endproperty

    a_no_store_after_reset: assert property (no_store_after_reset)
        else $error("store strobe high right after reset");
    a_pc_holds_on_stall: assert property (pc_holds_on_stall)
        else $error("pc moved during a load-use stall");
    a_hlt_known: assert property (hlt_known)
        else $error("hlt is unknown");

endmodule

bind tinker_core tinker_core_assertions chk0 (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .dmem_we   (dmem_req.we),
    .imem_addr (imem_addr),
    .hlt       (hlt)
);

// File: verification/tinker_core_tb.sv
`timescale 1ns/1ns

module tinker_core_tb;

    localparam tinker_pkg::addr_t IMEM_BASE  = 32'h2000;
    localparam int                IMEM_WORDS = 256;
    localparam int                DMEM_BYTES = 4096;

    logic                  clk;
    logic                  reset;
    tinker_pkg::instr_t    imem_data;
    tinker_pkg::data_t     dmem_rdata;
    tinker_pkg::addr_t     imem_addr;
    tinker_pkg::dmem_req_t dmem_req;
    logic                  hlt;

    tinker_pkg::instr_t imem [IMEM_WORDS];
    logic [7:0]         dmem [DMEM_BYTES];
    logic [31:0]        widx;         // word index into imem

    tinker_pkg::addr_t  got_addr [$]; // stores seen on the data port
    tinker_pkg::data_t  got_data [$];
    tinker_pkg::addr_t  exp_addr [$]; // stores the test predicts
    tinker_pkg::data_t  exp_data [$];

    int          prog_len;
    int          store_lit;   // next store offset from r0
    int          errors;
    int          checks;
    int          cycle_count;
    int          cycle_limit;

    tinker_core #(
        .PC_RESET_ADDR (IMEM_BASE)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .imem_data  (imem_data),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_req   (dmem_req),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // outside the program the instruction port reads as a bubble
    assign widx      = (imem_addr - IMEM_BASE) >> 2;
    assign imem_data = (widx < IMEM_WORDS) ? imem[widx[7:0]] : tinker_pkg::NOP_INSTR;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            dmem_rdata[8*i +: 8] = dmem[dmem_req.addr[11:0] + 12'(i)]; // little endian
        end
    end

    // commit stores mid-cycle while the request is stable
    always @(negedge clk) begin
        if (dmem_req.we) begin
            for (int i = 0; i < 8; i++) begin
                dmem[dmem_req.addr[11:0] + 12'(i)] = dmem_req.wdata[8*i +: 8];
            end
            got_addr.push_back(dmem_req.addr);
            got_data.push_back(dmem_req.wdata);
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, hlt never came", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [7:0] fill_byte(input int i);
        return 8'(i ^ (i >> 8)) ^ 8'h5a; // every address bit matters
    endfunction

    function automatic tinker_pkg::data_t fill_dword(input int a);
        tinker_pkg::data_t v;
        for (int i = 0; i < 8; i++) begin
            v[8*i +: 8] = fill_byte(a + i);
        end
        return v;
    endfunction

    function automatic tinker_pkg::data_t zext(input tinker_pkg::lit_t l);
        return {52'd0, l};
    endfunction

    task automatic compare_data(input string name, input tinker_pkg::data_t got,
                                input tinker_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input tinker_pkg::addr_t got,
                                input tinker_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // program builder
    task automatic new_program(input int store_base);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = tinker_pkg::NOP_INSTR;
        end
        for (int i = 0; i < DMEM_BYTES; i++) begin
            dmem[i] = fill_byte(i);
        end
        prog_len  = 0;
        store_lit = store_base;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input tinker_pkg::opcode_t op, input tinker_pkg::reg_idx_t rd,
                        input tinker_pkg::reg_idx_t rs, input tinker_pkg::reg_idx_t rt,
                        input tinker_pkg::lit_t lit);
        imem[prog_len] = {op, rd, rs, rt, lit}; // op rd rs rt L
        prog_len++;
    endtask

    task automatic patch_lit(input int pos, input int value);
        imem[pos][11:0] = 12'(value);
    endtask

    // store rt to r0 + L and predict it
    task automatic store_expect(input tinker_pkg::reg_idx_t r, input tinker_pkg::data_t val);
        emit(tinker_pkg::OP_STORE, 5'd0, 5'd0, r, 12'(store_lit));
        exp_addr.push_back(tinker_pkg::addr_t'(store_lit));
        exp_data.push_back(val);
        store_lit += 8;
    endtask

    task automatic check_stores;
        int n;
        if (got_addr.size() != exp_addr.size()) begin
            errors++;
            $display("store count wrong: %0d seen, %0d expected", got_addr.size(),
                     exp_addr.size());
        end
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            compare_addr("dmem_req.addr", got_addr[i], exp_addr[i]);
            compare_data("dmem_req.wdata", got_data[i], exp_data[i]);
        end
    endtask

    task automatic run_program;
        cycle_limit += 60 * prog_len;
        @(negedge clk);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        got_addr.delete();
        got_data.delete();
        reset = 1'b0;
        while (!hlt) @(negedge clk);
        if (got_addr.size() != exp_addr.size()) begin
            errors++;
            $display("hlt rose with %0d of %0d stores done", got_addr.size(), exp_addr.size());
        end
        repeat (10) @(negedge clk); // nothing more may be stored
        check_stores();
    endtask

    task automatic test_reset;
        new_program(0);
        emit(tinker_pkg::OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        cycle_limit += 60 * prog_len;
        reset = 1'b1;
        repeat (5) begin
            @(negedge clk);
            compare_addr("imem_addr", imem_addr, IMEM_BASE);
            compare_bit("dmem_req.we", dmem_req.we, 1'b0);
            compare_bit("hlt", hlt, 1'b0);
        end
        reset = 1'b0;
        #1 compare_addr("imem_addr", imem_addr, IMEM_BASE);
        @(negedge clk);
        compare_addr("imem_addr", imem_addr, IMEM_BASE + 32'd4);
        compare_bit("dmem_req.we", dmem_req.we, 1'b0);
        compare_bit("hlt", hlt, 1'b0);
        while (!hlt) @(negedge clk);
    endtask

    task automatic test_alu;
        tinker_pkg::data_t m [16];
        tinker_pkg::lit_t  la, lb, lc, ld, le, sh, sh2;
        la  = tinker_pkg::lit_t'($urandom_range(4095, 0));
        lb  = tinker_pkg::lit_t'($urandom_range(4095, 0));
        lc  = tinker_pkg::lit_t'($urandom_range(4095, 0));
        ld  = tinker_pkg::lit_t'($urandom_range(4095, 0));
        le  = tinker_pkg::lit_t'($urandom_range(4095, 0));
        sh  = tinker_pkg::lit_t'($urandom_range(15, 0));
        sh2 = tinker_pkg::lit_t'($urandom_range(15, 0));
        new_program(12'h100);
        emit(tinker_pkg::OP_MOV_RL, 5'd1, 5'd0, 5'd0, la);
        m[1] = zext(la);
        emit(tinker_pkg::OP_MOV_RL, 5'd2, 5'd0, 5'd0, lb);
        m[2] = zext(lb);
        emit(tinker_pkg::OP_ADD, 5'd3, 5'd1, 5'd2, 12'd0); // both operands forwarded
        m[3] = m[1] + m[2];
        store_expect(5'd3, m[3]);
        emit(tinker_pkg::OP_ADDI, 5'd3, 5'd0, 5'd0, lc);
        m[3] = m[3] + zext(lc);
        store_expect(5'd3, m[3]);
        emit(tinker_pkg::OP_SUB, 5'd4, 5'd3, 5'd1, 12'd0);
        m[4] = m[3] - m[1];
        emit(tinker_pkg::OP_SUBI, 5'd4, 5'd0, 5'd0, ld);
        m[4] = m[4] - zext(ld);
        store_expect(5'd4, m[4]);
        emit(tinker_pkg::OP_MUL, 5'd5, 5'd4, 5'd2, 12'd0);
        m[5] = m[4] * m[2];
        store_expect(5'd5, m[5]);
        emit(tinker_pkg::OP_XOR, 5'd6, 5'd5, 5'd1, 12'd0);
        m[6] = m[5] ^ m[1];
        emit(tinker_pkg::OP_AND, 5'd7, 5'd6, 5'd3, 12'd0);
        m[7] = m[6] & m[3];
        emit(tinker_pkg::OP_OR, 5'd8, 5'd7, 5'd2, 12'd0);
        m[8] = m[7] | m[2];
        store_expect(5'd8, m[8]);
        emit(tinker_pkg::OP_NOT, 5'd9, 5'd8, 5'd0, 12'd0);
        m[9] = ~m[8];
        store_expect(5'd9, m[9]);
        emit(tinker_pkg::OP_MOV_RL, 5'd11, 5'd0, 5'd0, sh);
        m[11] = zext(sh);
        emit(tinker_pkg::OP_SHFTR, 5'd10, 5'd9, 5'd11, 12'd0);
        m[10] = m[9] >> m[11];
        store_expect(5'd10, m[10]);
        emit(tinker_pkg::OP_SHFTL, 5'd12, 5'd10, 5'd11, 12'd0);
        m[12] = m[10] << m[11];
        emit(tinker_pkg::OP_SHFTRI, 5'd12, 5'd0, 5'd0, sh2);
        m[12] = m[12] >> sh2;
        emit(tinker_pkg::OP_SHFTLI, 5'd12, 5'd0, 5'd0, sh2);
        m[12] = m[12] << sh2;
        store_expect(5'd12, m[12]);
        emit(tinker_pkg::OP_MOV_RR, 5'd13, 5'd12, 5'd0, 12'd0);
        emit(tinker_pkg::OP_MOV_RL, 5'd13, 5'd0, 5'd0, le); // keeps upper bits
        m[13] = {m[12][63:12], le};
        store_expect(5'd13, m[13]);
        emit(tinker_pkg::OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program();
    endtask

    task automatic test_load_use;
        tinker_pkg::lit_t lx, ly;
        lx = tinker_pkg::lit_t'($urandom_range(4095, 0));
        ly = tinker_pkg::lit_t'($urandom_range(4095, 0));
        new_program(12'h200);
        emit(tinker_pkg::OP_MOV_RL, 5'd1, 5'd0, 5'd0, lx);
        emit(tinker_pkg::OP_MOV_RL, 5'd2, 5'd0, 5'd0, ly);
        store_expect(5'd1, zext(lx));                       // to 0x200
        emit(tinker_pkg::OP_LOAD, 5'd3, 5'd0, 5'd0, 12'h200);
        emit(tinker_pkg::OP_ADD, 5'd4, 5'd3, 5'd2, 12'd0);  // stalls one cycle
        store_expect(5'd4, zext(lx) + zext(ly));
        emit(tinker_pkg::OP_LOAD, 5'd5, 5'd0, 5'd0, 12'h300); // untouched fill
        emit(tinker_pkg::OP_ADD, 5'd6, 5'd2, 5'd5, 12'd0);
        store_expect(5'd6, fill_dword(12'h300) + zext(ly));
        emit(tinker_pkg::OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program();
    endtask

    task automatic test_branches;
        int p10, p11, p12;
        new_program(12'h400);
        emit(tinker_pkg::OP_MOV_RL, 5'd1, 5'd0, 5'd0, 12'd1);
        emit(tinker_pkg::OP_MOV_RL, 5'd2, 5'd0, 5'd0, 12'd5);
        emit(tinker_pkg::OP_MOV_RL, 5'd3, 5'd0, 5'd0, 12'd3);
        emit(tinker_pkg::OP_MOV_RL, 5'd9, 5'd0, 5'd0, 12'd2);
        emit(tinker_pkg::OP_SHFTLI, 5'd9, 5'd0, 5'd0, 12'd12); // r9 = 0x2000
        p10 = prog_len;
        emit(tinker_pkg::OP_MOV_RL, 5'd10, 5'd0, 5'd0, 12'd0); // offsets patched below
        emit(tinker_pkg::OP_ADD, 5'd10, 5'd10, 5'd9, 12'd0);
        p11 = prog_len;
        emit(tinker_pkg::OP_MOV_RL, 5'd11, 5'd0, 5'd0, 12'd0);
        emit(tinker_pkg::OP_ADD, 5'd11, 5'd11, 5'd9, 12'd0);
        p12 = prog_len;
        emit(tinker_pkg::OP_MOV_RL, 5'd12, 5'd0, 5'd0, 12'd0);
        emit(tinker_pkg::OP_ADD, 5'd12, 5'd12, 5'd9, 12'd0);
        emit(tinker_pkg::OP_MOV_RL, 5'd13, 5'd0, 5'd0, 12'd8); // skip one word
        repeat (3) emit(tinker_pkg::OP_MOV_RR, 5'd0, 5'd0, 5'd0, 12'd0); // no ID fwd
        emit(tinker_pkg::OP_BRNZ, 5'd10, 5'd1, 5'd0, 12'd0);   // taken
        emit(tinker_pkg::OP_STORE, 5'd0, 5'd0, 5'd1, 12'h7f0); // squashed
        patch_lit(p10, prog_len * 4);
        store_expect(5'd2, 64'd5);
        emit(tinker_pkg::OP_BRNZ, 5'd11, 5'd0, 5'd0, 12'd0);   // r0 is zero
        store_expect(5'd3, 64'd3);
        emit(tinker_pkg::OP_BRGT, 5'd11, 5'd2, 5'd3, 12'd0);   // 5 > 3 taken
        emit(tinker_pkg::OP_STORE, 5'd0, 5'd0, 5'd1, 12'h7f0);
        patch_lit(p11, prog_len * 4);
        store_expect(5'd1, 64'd1);
        emit(tinker_pkg::OP_BRGT, 5'd12, 5'd3, 5'd2, 12'd0);   // 3 > 5 not taken
        store_expect(5'd2, 64'd5);
        emit(tinker_pkg::OP_BR, 5'd12, 5'd0, 5'd0, 12'd0);
        emit(tinker_pkg::OP_STORE, 5'd0, 5'd0, 5'd1, 12'h7f0);
        patch_lit(p12, prog_len * 4);
        store_expect(5'd3, 64'd3);
        emit(tinker_pkg::OP_BRR_RD, 5'd13, 5'd0, 5'd0, 12'd0);
        emit(tinker_pkg::OP_STORE, 5'd0, 5'd0, 5'd1, 12'h7f0);
        store_expect(5'd13, 64'd8);
        emit(tinker_pkg::OP_BRR_L, 5'd0, 5'd0, 5'd0, 12'd8);
        emit(tinker_pkg::OP_STORE, 5'd0, 5'd0, 5'd1, 12'h7f0);
        store_expect(5'd9, 64'h2000);
        emit(tinker_pkg::OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program();
    endtask

    initial begin
        reset       = 1'b1;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        cycle_limit = 20; // reset and drain slack
        void'($urandom(32'h4046));
        test_reset();
        test_alu();
        test_load_use();
        test_branches();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/tinker_pkg.sv
rtl/tinker_fetch.sv
rtl/tinker_decode.sv
rtl/tinker_regfile.sv
rtl/tinker_execute.sv
rtl/tinker_writeback.sv
rtl/tinker_core.sv
verification/tinker_core_assertions.sv
verification/tinker_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the tinker core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tinker_core_tb -o tinker_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tinker_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0
